// ==== common/mips_isa_pkg.sv ====
package mips_isa_pkg;

	localparam int INST_W      = 32;
	localparam int OPCODE_W    = 6;
	localparam int FUNCT_W     = 6;
	localparam int REG_FIELD_W = 5;
	localparam int IMM16_W     = 16;

	typedef logic [INST_W-1:0]      inst_t;
	typedef logic [OPCODE_W-1:0]    opcode_t;
	typedef logic [FUNCT_W-1:0]     funct_t;
	typedef logic [REG_FIELD_W-1:0] shamt_t;
	typedef logic [IMM16_W-1:0]     imm16_t;

	// Primary opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_REGIMM  = 6'b000001;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_BLEZ    = 6'b000110;
	localparam opcode_t OP_BGTZ    = 6'b000111;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;

	// SPECIAL function codes
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	// REGIMM codes sit in the rt field
	localparam logic [REG_FIELD_W-1:0] RT_BLTZ = 5'b00000;
	localparam logic [REG_FIELD_W-1:0] RT_BGEZ = 5'b00001;

endpackage

// ==== common/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

	localparam int WORD_W   = 32;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0]           word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

	typedef enum logic [3:0]
	{
		ALU_NOP  = 4'd0,
		ALU_AND  = 4'd1,
		ALU_OR   = 4'd2,
		ALU_XOR  = 4'd3,
		ALU_NOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_ADD  = 4'd8,
		ALU_SUB  = 4'd9,
		ALU_SLT  = 4'd10,
		ALU_SLTU = 4'd11
	} alu_op_e;

	// Which ALU group drives the stage result
	typedef enum logic [1:0]
	{
		RES_NOP   = 2'd0,
		RES_LOGIC = 2'd1,
		RES_SHIFT = 2'd2,
		RES_ARITH = 2'd3
	} res_sel_e;

endpackage

// ==== hw/decode/id_decoder.sv ====
`timescale 1ns/100ps

module id_decoder
(
	input  mips_isa_pkg::inst_t      inst_i,
	output core_ctrl_pkg::alu_op_e   op_o,
	output core_ctrl_pkg::res_sel_e  sel_o,
	output logic                     we_o,
	output core_ctrl_pkg::reg_addr_t wd_o,
	output logic                     use_imm_o,
	output logic                     rs_zero_o,
	output core_ctrl_pkg::word_t     imm_o,
	output logic [2:0]               br_kind_o,
	output logic                     illegal_o
);

	// Bits [2:1] pick the branch test, bit 0 inverts it
	localparam logic [2:0] BR_NONE = 3'b000;
	localparam logic [2:0] BR_J    = 3'b001;
	localparam logic [2:0] BR_BEQ  = 3'b010;
	localparam logic [2:0] BR_BNE  = 3'b011;
	localparam logic [2:0] BR_BLTZ = 3'b100;
	localparam logic [2:0] BR_BGEZ = 3'b101;
	localparam logic [2:0] BR_BGTZ = 3'b110;
	localparam logic [2:0] BR_BLEZ = 3'b111;

	mips_isa_pkg::opcode_t    opcode;
	mips_isa_pkg::funct_t     funct;
	mips_isa_pkg::imm16_t     imm16;
	core_ctrl_pkg::reg_addr_t rt_field;
	core_ctrl_pkg::reg_addr_t rd_field;
	core_ctrl_pkg::word_t     imm_zext;
	core_ctrl_pkg::word_t     imm_sext;

	assign opcode   = inst_i[31:26];
	assign rt_field = inst_i[20:16];
	assign rd_field = inst_i[15:11];
	assign funct    = inst_i[5:0];
	assign imm16    = inst_i[15:0];
	assign imm_zext = {16'h0000, imm16};
	assign imm_sext = {{16{imm16[15]}}, imm16};

	////////////////////////////////////////////////////////////
	// Instruction tree
	////////////////////////////////////////////////////////////

	always_comb
	begin
		op_o      = core_ctrl_pkg::ALU_NOP;
		br_kind_o = BR_NONE;
		imm_o     = imm_sext;
		rs_zero_o = 1'b0;
		case (opcode)
			mips_isa_pkg::OP_SPECIAL:
			begin
				// Constant shifts take shamt in place of rs
				rs_zero_o = (funct == mips_isa_pkg::FN_SLL) || (funct == mips_isa_pkg::FN_SRL)
					|| (funct == mips_isa_pkg::FN_SRA);
				case (funct)
					mips_isa_pkg::FN_SLL:  op_o = core_ctrl_pkg::ALU_SLL;
					mips_isa_pkg::FN_SRL:  op_o = core_ctrl_pkg::ALU_SRL;
					mips_isa_pkg::FN_SRA:  op_o = core_ctrl_pkg::ALU_SRA;
					mips_isa_pkg::FN_SLLV: op_o = core_ctrl_pkg::ALU_SLL;
					mips_isa_pkg::FN_SRLV: op_o = core_ctrl_pkg::ALU_SRL;
					mips_isa_pkg::FN_SRAV: op_o = core_ctrl_pkg::ALU_SRA;
					mips_isa_pkg::FN_ADD:  op_o = core_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::FN_ADDU: op_o = core_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUB:  op_o = core_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::FN_SUBU: op_o = core_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  op_o = core_ctrl_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   op_o = core_ctrl_pkg::ALU_OR;
					mips_isa_pkg::FN_XOR:  op_o = core_ctrl_pkg::ALU_XOR;
					mips_isa_pkg::FN_NOR:  op_o = core_ctrl_pkg::ALU_NOR;
					mips_isa_pkg::FN_SLT:  op_o = core_ctrl_pkg::ALU_SLT;
					mips_isa_pkg::FN_SLTU: op_o = core_ctrl_pkg::ALU_SLTU;
					default:               op_o = core_ctrl_pkg::ALU_NOP;
				endcase
			end
			mips_isa_pkg::OP_REGIMM:
			begin
				case (rt_field)
					mips_isa_pkg::RT_BLTZ: br_kind_o = BR_BLTZ;
					mips_isa_pkg::RT_BGEZ: br_kind_o = BR_BGEZ;
					default:               br_kind_o = BR_NONE;
				endcase
			end
			mips_isa_pkg::OP_J:     br_kind_o = BR_J;
			mips_isa_pkg::OP_BEQ:   br_kind_o = BR_BEQ;
			mips_isa_pkg::OP_BNE:   br_kind_o = BR_BNE;
			mips_isa_pkg::OP_BLEZ:  br_kind_o = BR_BLEZ;
			mips_isa_pkg::OP_BGTZ:  br_kind_o = BR_BGTZ;
			mips_isa_pkg::OP_ADDI:  op_o = core_ctrl_pkg::ALU_ADD;
			mips_isa_pkg::OP_ADDIU: op_o = core_ctrl_pkg::ALU_ADD;
			mips_isa_pkg::OP_SLTI:  op_o = core_ctrl_pkg::ALU_SLT;
			mips_isa_pkg::OP_SLTIU: op_o = core_ctrl_pkg::ALU_SLTU;
			mips_isa_pkg::OP_ANDI:
			begin
				op_o  = core_ctrl_pkg::ALU_AND;
				imm_o = imm_zext;
			end
			mips_isa_pkg::OP_ORI:
			begin
				op_o  = core_ctrl_pkg::ALU_OR;
				imm_o = imm_zext;
			end
			mips_isa_pkg::OP_XORI:
			begin
				op_o  = core_ctrl_pkg::ALU_XOR;
				imm_o = imm_zext;
			end
			mips_isa_pkg::OP_LUI:
			begin
				op_o      = core_ctrl_pkg::ALU_OR;
				imm_o     = {imm16, 16'h0000};
				rs_zero_o = 1'b1;
			end
			default:
			begin
				op_o      = core_ctrl_pkg::ALU_NOP;
				br_kind_o = BR_NONE;
			end
		endcase
	end

	always_comb
	begin
		case (op_o)
			core_ctrl_pkg::ALU_AND, core_ctrl_pkg::ALU_OR,
			core_ctrl_pkg::ALU_XOR, core_ctrl_pkg::ALU_NOR:
				sel_o = core_ctrl_pkg::RES_LOGIC;
			core_ctrl_pkg::ALU_SLL, core_ctrl_pkg::ALU_SRL, core_ctrl_pkg::ALU_SRA:
				sel_o = core_ctrl_pkg::RES_SHIFT;
			core_ctrl_pkg::ALU_ADD, core_ctrl_pkg::ALU_SUB,
			core_ctrl_pkg::ALU_SLT, core_ctrl_pkg::ALU_SLTU:
				sel_o = core_ctrl_pkg::RES_ARITH;
			default:
				sel_o = core_ctrl_pkg::RES_NOP;
		endcase
	end

	// Opcodes 0x08..0x0f form the immediate ALU group, all of them kept
	assign use_imm_o = (opcode[5:3] == 3'b001);
	assign wd_o      = use_imm_o ? rt_field : rd_field;

	// Every ALU op writes, branches never do
	assign we_o      = (op_o != core_ctrl_pkg::ALU_NOP) && (wd_o != '0);
	assign illegal_o = (op_o == core_ctrl_pkg::ALU_NOP) && (br_kind_o == BR_NONE);

endmodule

// ==== hw/decode/id_stage.sv ====
`timescale 1ns/100ps

module id_stage
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     inst_valid_i,
	input  mips_isa_pkg::inst_t      inst_i,
	input  core_ctrl_pkg::word_t     pc_i,
	output core_ctrl_pkg::reg_addr_t rs_addr_o,
	output core_ctrl_pkg::reg_addr_t rt_addr_o,
	input  core_ctrl_pkg::word_t     rs_data_i,
	input  core_ctrl_pkg::word_t     rt_data_i,
	input  logic                     ex_we_i,
	input  core_ctrl_pkg::reg_addr_t ex_addr_i,
	input  core_ctrl_pkg::word_t     ex_data_i,
	input  logic                     wb_we_i,
	input  core_ctrl_pkg::reg_addr_t wb_addr_i,
	input  core_ctrl_pkg::word_t     wb_data_i,
	output core_ctrl_pkg::alu_op_e   op_o,
	output core_ctrl_pkg::res_sel_e  sel_o,
	output core_ctrl_pkg::word_t     opa_o,
	output core_ctrl_pkg::word_t     opb_o,
	output logic                     we_o,
	output core_ctrl_pkg::reg_addr_t wd_o,
	output logic                     branch_taken_o,
	output core_ctrl_pkg::word_t     branch_target_o,
	output logic                     illegal_o
);

	core_ctrl_pkg::alu_op_e   dec_op;
	core_ctrl_pkg::res_sel_e  dec_sel;
	logic                     dec_we;
	core_ctrl_pkg::reg_addr_t dec_wd;
	logic                     dec_use_imm;
	logic                     dec_rs_zero;
	core_ctrl_pkg::word_t     dec_imm;
	logic [2:0]               dec_br_kind;
	logic                     dec_illegal;

	core_ctrl_pkg::word_t     rs_val;
	core_ctrl_pkg::word_t     rt_val;
	core_ctrl_pkg::word_t     opa;
	core_ctrl_pkg::word_t     opb;
	mips_isa_pkg::shamt_t     shamt;
	core_ctrl_pkg::word_t     pc_plus4;
	logic                     cond;
	logic                     taken;
	core_ctrl_pkg::word_t     target;

	// Newest writer wins
	function automatic core_ctrl_pkg::word_t fwd
	(
		input core_ctrl_pkg::reg_addr_t addr,
		input core_ctrl_pkg::word_t     rf_data
	);
		if (ex_we_i && (ex_addr_i == addr))
			return ex_data_i;
		else if (wb_we_i && (wb_addr_i == addr))
			return wb_data_i;
		else
			return rf_data;
	endfunction

	id_decoder id_decoder_i
	(
		.inst_i    (inst_i),
		.op_o      (dec_op),
		.sel_o     (dec_sel),
		.we_o      (dec_we),
		.wd_o      (dec_wd),
		.use_imm_o (dec_use_imm),
		.rs_zero_o (dec_rs_zero),
		.imm_o     (dec_imm),
		.br_kind_o (dec_br_kind),
		.illegal_o (dec_illegal)
	);

	assign rs_addr_o = inst_i[25:21];
	assign rt_addr_o = inst_i[20:16];
	assign shamt     = inst_i[10:6];

	always_comb
	begin
		rs_val = fwd(rs_addr_o, rs_data_i);
		rt_val = fwd(rt_addr_o, rt_data_i);
	end

	// lui sees zero on A, constant shifts see shamt
	assign opa = dec_rs_zero ?
		((dec_sel == core_ctrl_pkg::RES_SHIFT) ? core_ctrl_pkg::word_t'(shamt) : '0) : rs_val;
	assign opb = dec_use_imm ? dec_imm : rt_val;

	////////////////////////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////////////////////////

	assign pc_plus4 = pc_i + 32'd4;

	// Kind encoding as in id_decoder
	always_comb
	begin
		case (dec_br_kind[2:1])
			2'b01:   cond = (rs_val == rt_val);
			2'b10:   cond = rs_val[31];
			2'b11:   cond = !rs_val[31] && (rs_val != '0);
			default: cond = 1'b0;
		endcase
		taken = cond ^ dec_br_kind[0];
		if (dec_br_kind[2:1] == 2'b00)
			target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
		else
			target = pc_plus4 + {dec_imm[29:0], 2'b00};
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			we_o           <= 1'b0;
			branch_taken_o <= 1'b0;
			illegal_o      <= 1'b0;
		end
		else
		begin
			we_o           <= inst_valid_i && dec_we && !dec_illegal;
			branch_taken_o <= inst_valid_i && taken;
			illegal_o      <= inst_valid_i && dec_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		op_o            <= dec_op;
		sel_o           <= dec_sel;
		opa_o           <= opa;
		opb_o           <= opb;
		wd_o            <= dec_wd;
		branch_target_o <= target;
	end

endmodule

// ==== hw/execute/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  core_ctrl_pkg::alu_op_e   op_i,
	input  core_ctrl_pkg::res_sel_e  sel_i,
	input  core_ctrl_pkg::word_t     opa_i,
	input  core_ctrl_pkg::word_t     opb_i,
	input  logic                     we_i,
	input  core_ctrl_pkg::reg_addr_t wd_i,
	output logic                     fwd_we_o,
	output core_ctrl_pkg::reg_addr_t fwd_addr_o,
	output core_ctrl_pkg::word_t     fwd_data_o,
	output logic                     wb_valid_o,
	output core_ctrl_pkg::reg_addr_t wb_addr_o,
	output core_ctrl_pkg::word_t     wb_data_o
);

	mips_isa_pkg::shamt_t shamt;
	core_ctrl_pkg::word_t logic_res;
	core_ctrl_pkg::word_t shift_res;
	core_ctrl_pkg::word_t arith_res;
	core_ctrl_pkg::word_t result;

	assign shamt = opa_i[4:0];

	always_comb
	begin
		case (op_i)
			core_ctrl_pkg::ALU_AND: logic_res = opa_i & opb_i;
			core_ctrl_pkg::ALU_OR:  logic_res = opa_i | opb_i;
			core_ctrl_pkg::ALU_XOR: logic_res = opa_i ^ opb_i;
			core_ctrl_pkg::ALU_NOR: logic_res = ~(opa_i | opb_i);
			default:                logic_res = '0;
		endcase
	end

	always_comb
	begin
		case (op_i)
			core_ctrl_pkg::ALU_SLL: shift_res = opb_i << shamt;
			core_ctrl_pkg::ALU_SRL: shift_res = opb_i >> shamt;
			core_ctrl_pkg::ALU_SRA: shift_res = $signed(opb_i) >>> shamt;
			default:                shift_res = '0;
		endcase
	end

	// No overflow trap, add and addu are the same
	always_comb
	begin
		case (op_i)
			core_ctrl_pkg::ALU_ADD:  arith_res = opa_i + opb_i;
			core_ctrl_pkg::ALU_SUB:  arith_res = opa_i - opb_i;
			core_ctrl_pkg::ALU_SLT:  arith_res = {31'b0, $signed(opa_i) < $signed(opb_i)};
			core_ctrl_pkg::ALU_SLTU: arith_res = {31'b0, opa_i < opb_i};
			default:                 arith_res = '0;
		endcase
	end

	always_comb
	begin
		case (sel_i)
			core_ctrl_pkg::RES_LOGIC: result = logic_res;
			core_ctrl_pkg::RES_SHIFT: result = shift_res;
			core_ctrl_pkg::RES_ARITH: result = arith_res;
			default:                  result = '0;
		endcase
	end

	assign fwd_we_o   = we_i;
	assign fwd_addr_o = wd_i;
	assign fwd_data_o = result;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= we_i;
	end

	always_ff @(posedge clk)
	begin
		wb_addr_o <= wd_i;
		wb_data_o <= result;
	end

endmodule

// ==== hw/result/wb_regfile.sv ====
`timescale 1ns/100ps

module wb_regfile
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     we_i,
	input  core_ctrl_pkg::reg_addr_t waddr_i,
	input  core_ctrl_pkg::word_t     wdata_i,
	input  core_ctrl_pkg::reg_addr_t raddr_a_i,
	input  core_ctrl_pkg::reg_addr_t raddr_b_i,
	output core_ctrl_pkg::word_t     rdata_a_o,
	output core_ctrl_pkg::word_t     rdata_b_o
);

	core_ctrl_pkg::word_t regs [core_ctrl_pkg::NUM_REGS];

	// $zero never takes a write
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int i = 0; i < core_ctrl_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we_i && (waddr_i != '0))
		begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

endmodule

// ==== hw/mips_core_top.sv ====
`timescale 1ns/100ps

module mips_core_top
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     inst_valid_i,
	input  mips_isa_pkg::inst_t      inst_i,
	input  core_ctrl_pkg::word_t     pc_i,
	output logic                     wb_valid_o,
	output core_ctrl_pkg::reg_addr_t wb_addr_o,
	output core_ctrl_pkg::word_t     wb_data_o,
	output logic                     branch_taken_o,
	output core_ctrl_pkg::word_t     branch_target_o,
	output logic                     illegal_o
);

	core_ctrl_pkg::reg_addr_t rs_addr;
	core_ctrl_pkg::reg_addr_t rt_addr;
	core_ctrl_pkg::word_t     rs_data;
	core_ctrl_pkg::word_t     rt_data;

	// Decode to execute
	core_ctrl_pkg::alu_op_e   ex_op;
	core_ctrl_pkg::res_sel_e  ex_sel;
	core_ctrl_pkg::word_t     ex_opa;
	core_ctrl_pkg::word_t     ex_opb;
	logic                     ex_we;
	core_ctrl_pkg::reg_addr_t ex_wd;

	// Execute result back to decode
	logic                     fwd_we;
	core_ctrl_pkg::reg_addr_t fwd_addr;
	core_ctrl_pkg::word_t     fwd_data;

	id_stage id_stage_i
	(
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.rs_addr_o       (rs_addr),
		.rt_addr_o       (rt_addr),
		.rs_data_i       (rs_data),
		.rt_data_i       (rt_data),
		.ex_we_i         (fwd_we),
		.ex_addr_i       (fwd_addr),
		.ex_data_i       (fwd_data),
		.wb_we_i         (wb_valid_o),
		.wb_addr_i       (wb_addr_o),
		.wb_data_i       (wb_data_o),
		.op_o            (ex_op),
		.sel_o           (ex_sel),
		.opa_o           (ex_opa),
		.opb_o           (ex_opb),
		.we_o            (ex_we),
		.wd_o            (ex_wd),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

	ex_stage ex_stage_i
	(
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.op_i       (ex_op),
		.sel_i      (ex_sel),
		.opa_i      (ex_opa),
		.opb_i      (ex_opb),
		.we_i       (ex_we),
		.wd_i       (ex_wd),
		.fwd_we_o   (fwd_we),
		.fwd_addr_o (fwd_addr),
		.fwd_data_o (fwd_data),
		.wb_valid_o (wb_valid_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

	wb_regfile wb_regfile_i
	(
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.we_i      (wb_valid_o),
		.waddr_i   (wb_addr_o),
		.wdata_i   (wb_data_o),
		.raddr_a_i (rs_addr),
		.raddr_b_i (rt_addr),
		.rdata_a_o (rs_data),
		.rdata_b_o (rt_data)
	);

endmodule

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/100ps

module tb_mips_core;

	localparam int NUM_INSTS   = 400;
	localparam int DRAIN_LIMIT = 20;

	// R-type function codes picked by a 4-bit index
	localparam logic [95:0] FUNCT_TAB =
	{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
		6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};

	logic        clk;
	logic        arst_n_i;
	logic        inst_valid_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic        wb_valid_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;
	logic        branch_taken_o;
	logic [31:0] branch_target_o;
	logic        illegal_o;

	logic [31:0] rng_state;
	logic [31:0] arch_regs [32];
	int          cyc = 0;

	// Expected outcomes tagged with their due cycle
	int          fl_due_q [$];
	logic        fl_taken_q [$];
	logic [31:0] fl_target_q [$];
	logic        fl_illegal_q [$];
	int          wb_due_q [$];
	logic [4:0]  wb_addr_q [$];
	logic [31:0] wb_data_q [$];

	mips_core_top mips_core_top_i
	(
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.wb_valid_o      (wb_valid_o),
		.wb_addr_o       (wb_addr_o),
		.wb_data_o       (wb_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s at cycle %0d: expected %h, actual %h",
				name, cyc, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// Program generation and reference model
	////////////////////////////////////////////////////////////

	// Registers limited to r0..r7 so neighbours depend on each other
	function automatic logic [31:0] gen_inst(input logic [31:0] sel, input logic [31:0] fld);
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] inst;
		rs = {2'b00, fld[2:0]};
		rt = {2'b00, fld[5:3]};
		rd = {2'b00, fld[8:6]};
		case (sel[11:8])
			4'd6, 4'd7, 4'd8, 4'd9:
				inst = {3'b001, sel[14:12], rs, rt, fld[31:16]};
			4'd10, 4'd11:
			begin
				case (sel[14:12])
					3'd0, 3'd6: inst = {6'h04, rs, rt, fld[31:16]};
					3'd1, 3'd7: inst = {6'h05, rs, rt, fld[31:16]};
					3'd2:       inst = {6'h06, rs, 5'd0, fld[31:16]};
					3'd3:       inst = {6'h07, rs, 5'd0, fld[31:16]};
					3'd4:       inst = {6'h01, rs, 5'd0, fld[31:16]};
					default:    inst = {6'h01, rs, 5'd1, fld[31:16]};
				endcase
			end
			4'd12:
				inst = {6'h02, fld[25:0]};
			4'd13:
			begin
				// jal, lw, jr and bgezal are all outside the core
				case (sel[13:12])
					2'd0:    inst = {6'h03, fld[25:0]};
					2'd1:    inst = {6'h23, rs, rt, fld[31:16]};
					2'd2:    inst = {6'h00, rs, 15'd0, 6'h08};
					default: inst = {6'h01, rs, 5'h11, fld[31:16]};
				endcase
			end
			default:
				inst = {6'h00, rs, rt, rd, fld[13:9], FUNCT_TAB[sel[15:12]*6 +: 6]};
		endcase
		return inst;
	endfunction

	function automatic void ref_exec
	(
		input  logic [31:0] inst,
		input  logic [31:0] pc,
		output logic        we,
		output logic [4:0]  dst,
		output logic [31:0] res,
		output logic        taken,
		output logic [31:0] target,
		output logic        illegal
	);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] pc4;
		logic [4:0]  sh;
		a       = arch_regs[inst[25:21]];
		b       = arch_regs[inst[20:16]];
		sh      = inst[10:6];
		simm    = {{16{inst[15]}}, inst[15:0]};
		zimm    = {16'h0000, inst[15:0]};
		pc4     = pc + 32'd4;
		// Immediate ALU group writes rt
		we      = (inst[31:26] >= 6'h08) && (inst[31:26] <= 6'h0f);
		dst     = inst[20:16];
		res     = '0;
		taken   = 1'b0;
		target  = pc4 + (simm << 2);
		illegal = 1'b0;
		case (inst[31:26])
			6'h00:
			begin
				we  = 1'b1;
				dst = inst[15:11];
				case (inst[5:0])
					6'h00:        res = b << sh;
					6'h02:        res = b >> sh;
					6'h03:        res = $signed(b) >>> sh;
					6'h04:        res = b << a[4:0];
					6'h06:        res = b >> a[4:0];
					6'h07:        res = $signed(b) >>> a[4:0];
					6'h20, 6'h21: res = a + b;
					6'h22, 6'h23: res = a - b;
					6'h24:        res = a & b;
					6'h25:        res = a | b;
					6'h26:        res = a ^ b;
					6'h27:        res = ~(a | b);
					6'h2a:        res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					6'h2b:        res = (a < b) ? 32'd1 : 32'd0;
					default:
					begin
						we      = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			6'h01:
			begin
				if (inst[20:16] == 5'd0)
					taken = a[31];
				else if (inst[20:16] == 5'd1)
					taken = !a[31];
				else
					illegal = 1'b1;
			end
			6'h02:
			begin
				taken  = 1'b1;
				target = {pc4[31:28], inst[25:0], 2'b00};
			end
			6'h04:        taken = (a == b);
			6'h05:        taken = (a != b);
			6'h06:        taken = a[31] || (a == 32'd0);
			6'h07:        taken = !a[31] && (a != 32'd0);
			6'h08, 6'h09: res = a + simm;
			6'h0a:        res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			6'h0b:        res = (a < simm) ? 32'd1 : 32'd0;
			6'h0c:        res = a & zimm;
			6'h0d:        res = a | zimm;
			6'h0e:        res = a ^ zimm;
			6'h0f:        res = {inst[15:0], 16'h0000};
			default:      illegal = 1'b1;
		endcase
		// $zero ignores writes
		if (dst == 5'd0)
			we = 1'b0;
		if (we)
			arch_regs[dst] = res;
	endfunction

	////////////////////////////////////////////////////////////
	// Output comparison
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (arst_n_i)
		begin
			if ((fl_due_q.size() > 0) && (fl_due_q[0] == cyc))
			begin
				check_value("branch_taken_o", fl_taken_q[0], branch_taken_o);
				if (fl_taken_q[0])
					check_value("branch_target_o", fl_target_q[0], branch_target_o);
				check_value("illegal_o", fl_illegal_q[0], illegal_o);
				fl_due_q.delete(0);
				fl_taken_q.delete(0);
				fl_target_q.delete(0);
				fl_illegal_q.delete(0);
			end
			else
			begin
				check_value("branch_taken_o idle", 32'd0, branch_taken_o);
				check_value("illegal_o idle", 32'd0, illegal_o);
			end
			if ((wb_due_q.size() > 0) && (wb_due_q[0] == cyc))
			begin
				check_value("wb_valid_o", 32'd1, wb_valid_o);
				check_value("wb_addr_o", wb_addr_q[0], wb_addr_o);
				check_value("wb_data_o", wb_data_q[0], wb_data_o);
				wb_due_q.delete(0);
				wb_addr_q.delete(0);
				wb_data_q.delete(0);
			end
			else
				check_value("wb_valid_o idle", 32'd0, wb_valid_o);
		end
	end

	initial
	begin
		logic [31:0] sel;
		logic [31:0] fld;
		logic [31:0] inst;
		logic [31:0] pc;
		logic        we;
		logic [4:0]  dst;
		logic [31:0] res;
		logic        taken;
		logic [31:0] target;
		logic        illegal;
		int          wait_cycles;

		clk          = 1'b0;
		arst_n_i     = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		rng_state    = 32'hc2cccb94;
		for (int i = 0; i < 32; i++)
			arch_regs[i] = '0;

		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		// Idle slots keep the outputs low
		repeat (4) @(posedge clk);

		for (int n = 0; n < NUM_INSTS; n++)
		begin
			@(posedge clk);
			rng_state = xorshift32(rng_state);
			sel       = rng_state;
			rng_state = xorshift32(rng_state);
			fld       = rng_state;
			rng_state = xorshift32(rng_state);
			pc        = {rng_state[31:2], 2'b00};
			if (sel[3:0] == 4'hf)
			begin
				// Bubble with garbage on the bus
				inst_valid_i <= 1'b0;
				inst_i       <= fld;
				pc_i         <= pc;
			end
			else
			begin
				inst = gen_inst(sel, fld);
				ref_exec(inst, pc, we, dst, res, taken, target, illegal);
				fl_due_q.push_back(cyc + 2);
				fl_taken_q.push_back(taken);
				fl_target_q.push_back(target);
				fl_illegal_q.push_back(illegal);
				if (we)
				begin
					wb_due_q.push_back(cyc + 3);
					wb_addr_q.push_back(dst);
					wb_data_q.push_back(res);
				end
				inst_valid_i <= 1'b1;
				inst_i       <= inst;
				pc_i         <= pc;
			end
		end
		@(posedge clk);
		inst_valid_i <= 1'b0;

		wait_cycles = 0;
		while (((fl_due_q.size() > 0) || (wb_due_q.size() > 0)) && (wait_cycles < DRAIN_LIMIT))
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if ((fl_due_q.size() == 0) && (wb_due_q.size() == 0))
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
			abort_run("Pipeline did not drain in time, expected results are still pending");
	end

endmodule

// ==== files.f ====
common/mips_isa_pkg.sv
common/core_ctrl_pkg.sv
hw/decode/id_decoder.sv
hw/decode/id_stage.sv
hw/execute/ex_stage.sv
hw/result/wb_regfile.sv
hw/mips_core_top.sv
verif/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - common/mips_isa_pkg.sv
  - common/core_ctrl_pkg.sv
  - hw/decode/id_decoder.sv
  - hw/decode/id_stage.sv
  - hw/execute/ex_stage.sv
  - hw/result/wb_regfile.sv
  - hw/mips_core_top.sv
  - target: test
    files:
      - verif/tb_mips_core.sv
